// File: source/qpi_cache_pkg.sv
package qpi_cache_pkg;

	// Requester side addresses 32-bit words
	localparam int ADDR_WIDTH = 12;

	// Cache geometry
	localparam int LINE_WORDS = 4;
	localparam int LINE_COUNT = 32;

	// Fixed at two, the replacement logic keeps a single LRU bit per set
	localparam int WAYS = 2;
	localparam int SETS = LINE_COUNT / WAYS;

	// Address split is {tag, set, offset}
	localparam int OFFSET_BITS = $clog2(LINE_WORDS);
	localparam int SET_BITS = $clog2(SETS);
	localparam int TAG_BITS = ADDR_WIDTH - SET_BITS - OFFSET_BITS;

	// Byte address towards the quad-SPI controller
	localparam int QADDR_WIDTH = ADDR_WIDTH + 2;

	// Per-set flag word
	localparam int FLAG_WIDTH = 3;
	// Way to replace next
	localparam int FLAG_LRU = 0;
	// Way 0 matches memory
	localparam int FLAG_CLEAN0 = 1;
	// Way 1 matches memory
	localparam int FLAG_CLEAN1 = 2;

	// Both ways clean and way 0 replaced first
	localparam logic [FLAG_WIDTH-1:0] FLAG_INIT =
		FLAG_WIDTH'((1 << FLAG_CLEAN0) | (1 << FLAG_CLEAN1));

	// Line data array depth in words
	localparam int DATA_DEPTH = LINE_COUNT * LINE_WORDS;

endpackage

// File: source/cache_ctrl_if.sv
`timescale 1ns/1ps

interface cache_ctrl_if;
	import qpi_cache_pkg::*;

	// Lookup results
	logic                   hit;
	logic                   hit_way;
	logic                   lru_way;
	logic                   lru_clean;
	logic [TAG_BITS-1:0]    lru_tag;

	// Sequencer state and strobes
	logic                   busy;
	logic [OFFSET_BITS-1:0] line_offset;
	logic                   fill_wen;
	logic                   tag_write;
	logic                   clean_write;

	// Registered data array word, used as writeback data
	logic [31:0]            store_rdata;

	modport lookup (output hit, hit_way, lru_way, lru_clean, lru_tag,
		input busy, tag_write, clean_write);

	modport refill (input hit, lru_clean, lru_tag, store_rdata,
		output busy, line_offset, fill_wen, tag_write, clean_write);

	modport store (input hit, hit_way, lru_way, busy, line_offset, fill_wen,
		output store_rdata);

endinterface

// File: source/cache_tag_lookup.sv
`timescale 1ns/1ps

module cache_tag_lookup (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic [qpi_cache_pkg::ADDR_WIDTH-1:0] addr,
	input  logic                                 ren,
	input  logic [3:0]                           wen,
	cache_ctrl_if.lookup                         ctrl
);
	import qpi_cache_pkg::*;

	logic [TAG_BITS-1:0]   addr_tag;
	logic [SET_BITS-1:0]   addr_set;
	logic [SET_BITS-1:0]   set_q;
	logic [TAG_BITS-1:0]   tag_mem [WAYS][SETS];
	logic [TAG_BITS-1:0]   tag_q [WAYS];
	logic [SETS-1:0]       valid_mem [WAYS];
	logic [WAYS-1:0]       valid_q;
	logic [FLAG_WIDTH-1:0] flag_mem [SETS];
	logic [FLAG_WIDTH-1:0] flag_q;
	logic [FLAG_WIDTH-1:0] flag_wdata;
	logic                  flag_we;
	logic [WAYS-1:0]       way_match;
	logic                  hit;
	logic                  hit_way;
	logic                  lru;

	assign addr_tag = addr[ADDR_WIDTH-1 -: TAG_BITS];
	assign addr_set = addr[OFFSET_BITS +: SET_BITS];

	// Stored tags only count when they were read for the current set
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			way_match[w] = valid_q[w] && (set_q == addr_set) && (tag_q[w] == addr_tag);
		end
	end

	assign hit = |way_match;
	// Way 1 wins only if it matches, tags within a set are distinct
	assign hit_way = way_match[1];
	assign lru = flag_q[FLAG_LRU];

	assign ctrl.hit = hit;
	assign ctrl.hit_way = hit_way;
	assign ctrl.lru_way = lru;
	assign ctrl.lru_clean = lru ? flag_q[FLAG_CLEAN1] : flag_q[FLAG_CLEAN0];
	assign ctrl.lru_tag = tag_q[lru];

	// New flag word for the addressed set
	always_comb begin
		flag_wdata = flag_q;
		flag_we = 1'b0;
		if (hit && !ctrl.busy && (ren || (wen != 4'b0000))) begin
			flag_we = 1'b1;
			// The other way becomes the replacement candidate
			flag_wdata[FLAG_LRU] = ~hit_way;
			// Any byte write leaves the hit line dirty
			if (wen != 4'b0000) begin
				flag_wdata[FLAG_CLEAN0 + hit_way] = 1'b0;
			end
		end else if (ctrl.tag_write || ctrl.clean_write) begin
			// Refilled or written-back line now matches memory
			flag_we = 1'b1;
			flag_wdata[FLAG_CLEAN0 + lru] = 1'b1;
		end
	end

	// Tag arrays with synchronous read
	always_ff @(posedge clk) begin
		set_q <= addr_set;
		for (int w = 0; w < WAYS; w++) begin
			tag_q[w] <= tag_mem[w][addr_set];
		end
		if (ctrl.tag_write) begin
			tag_mem[lru][addr_set] <= addr_tag;
			// Write-first so the retried lookup sees the new tag
			tag_q[lru] <= addr_tag;
		end
	end

	// Valid bits and flags
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < WAYS; w++) begin
				valid_mem[w] <= '0;
			end
			valid_q <= '0;
			for (int s = 0; s < SETS; s++) begin
				flag_mem[s] <= FLAG_INIT;
			end
			flag_q <= FLAG_INIT;
		end else begin
			for (int w = 0; w < WAYS; w++) begin
				valid_q[w] <= valid_mem[w][addr_set];
			end
			if (ctrl.tag_write) begin
				valid_mem[lru][addr_set] <= 1'b1;
				valid_q[lru] <= 1'b1;
			end
			// Flag read also write-first, keeps back-to-back updates coherent
			flag_q <= flag_we ? flag_wdata : flag_mem[addr_set];
			if (flag_we) begin
				flag_mem[addr_set] <= flag_wdata;
			end
		end
	end

endmodule

// File: source/cache_refill_seq.sv
`timescale 1ns/1ps

module cache_refill_seq (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic [qpi_cache_pkg::ADDR_WIDTH-1:0]  addr,
	input  logic                                  ren,
	input  logic [3:0]                            wen,
	output logic                                  ready,
	output logic                                  qpi_do_read,
	output logic                                  qpi_do_write,
	input  logic                                  qpi_next_byte,
	output logic [qpi_cache_pkg::QADDR_WIDTH-1:0] qpi_addr,
	output logic [31:0]                           qpi_wdata,
	input  logic                                  qpi_is_idle,
	cache_ctrl_if.refill                          ctrl
);
	import qpi_cache_pkg::*;

	logic [ADDR_WIDTH-1:0]  addr_q;
	logic                   req;
	logic                   req_q;
	logic                   fresh;
	logic                   busy;
	logic                   pending;
	logic [OFFSET_BITS-1:0] word_q;
	logic                   wb_step;
	logic                   fill_wen_q;
	logic                   tag_write_q;
	logic                   clean_write_q;

	assign req = ren || (wen != 4'b0000);
	// Lookup outputs belong to this request once it has been held for a cycle
	assign fresh = req && req_q && (addr == addr_q);
	assign busy = qpi_do_read || qpi_do_write;
	// Array updates still in flight from the last transfer
	assign pending = fill_wen_q || tag_write_q || clean_write_q;
	assign wb_step = qpi_do_write && qpi_next_byte;

	// Writeback data comes straight out of the data array
	assign qpi_wdata = ctrl.store_rdata;

	assign ctrl.busy = busy;
	assign ctrl.fill_wen = fill_wen_q;
	assign ctrl.tag_write = tag_write_q;
	assign ctrl.clean_write = clean_write_q;

	// Refill writes land one cycle after their strobe, so step back one word
	// Writeback reads look one word ahead so data is ready for the next strobe
	assign ctrl.line_offset = fill_wen_q ? word_q - 1'b1
		: word_q + {{(OFFSET_BITS-1){1'b0}}, wb_step};

	always_ff @(posedge clk) begin
		if (rst) begin
			ready <= 1'b0;
			qpi_do_read <= 1'b0;
			qpi_do_write <= 1'b0;
			qpi_addr <= '0;
			word_q <= '0;
			fill_wen_q <= 1'b0;
			tag_write_q <= 1'b0;
			clean_write_q <= 1'b0;
			addr_q <= '0;
			req_q <= 1'b0;
		end else begin
			addr_q <= addr;
			req_q <= req;
			ready <= 1'b0;
			fill_wen_q <= 1'b0;
			tag_write_q <= 1'b0;
			clean_write_q <= 1'b0;
			if (busy) begin
				// One word moved per strobe
				if (qpi_next_byte) begin
					qpi_addr[OFFSET_BITS+1:2] <= qpi_addr[OFFSET_BITS+1:2] + 1'b1;
					word_q <= word_q + 1'b1;
					fill_wen_q <= qpi_do_read;
					if (&word_q) begin
						// Last word, counter wraps back to zero for the next transfer
						qpi_do_read <= 1'b0;
						qpi_do_write <= 1'b0;
						tag_write_q <= qpi_do_read;
						clean_write_q <= qpi_do_write;
					end
				end
			end else if (fresh && ctrl.hit) begin
				// Single pulse while the request is still held
				ready <= !ready;
			end else if (fresh && !pending && qpi_is_idle) begin
				word_q <= '0;
				if (!ctrl.lru_clean) begin
					// Dirty victim goes out first
					qpi_do_write <= 1'b1;
					qpi_addr <= {ctrl.lru_tag, addr[OFFSET_BITS +: SET_BITS],
						{(OFFSET_BITS+2){1'b0}}};
				end else begin
					// Victim is clean, fetch the requested line
					qpi_do_read <= 1'b1;
					qpi_addr <= {addr[ADDR_WIDTH-1:OFFSET_BITS], {(OFFSET_BITS+2){1'b0}}};
				end
			end
		end
	end

endmodule

// File: source/cache_data_store.sv
`timescale 1ns/1ps

module cache_data_store (
	input  logic                                 clk,
	input  logic [qpi_cache_pkg::ADDR_WIDTH-1:0] addr,
	input  logic [3:0]                           wen,
	input  logic [31:0]                          wdata,
	input  logic [31:0]                          qpi_rdata,
	output logic [31:0]                          rdata,
	cache_ctrl_if.store                          ctrl
);
	import qpi_cache_pkg::*;

	logic [31:0]                   mem [DATA_DEPTH];
	logic [$clog2(DATA_DEPTH)-1:0] word_addr;
	logic [3:0]                    byte_en;
	logic [31:0]                   din;
	logic [31:0]                   fill_data;
	logic [31:0]                   rdata_q;
	logic                          host_side;

	// Requester owns the array on a hit outside a transfer
	assign host_side = ctrl.hit && !ctrl.busy;

	// Word address is {way, set, offset}
	always_comb begin
		if (host_side) begin
			word_addr = {ctrl.hit_way, addr[OFFSET_BITS +: SET_BITS], addr[OFFSET_BITS-1:0]};
			byte_en = wen;
			din = wdata;
		end else begin
			// Sequencer side, LRU way of the addressed set
			word_addr = {ctrl.lru_way, addr[OFFSET_BITS +: SET_BITS], ctrl.line_offset};
			byte_en = {4{ctrl.fill_wen}};
			din = fill_data;
		end
	end

	always_ff @(posedge clk) begin
		// Refill word as it was on the strobe
		fill_data <= qpi_rdata;
		for (int b = 0; b < 4; b++) begin
			if (byte_en[b]) begin
				mem[word_addr][8*b +: 8] <= din[8*b +: 8];
			end
		end
		// Read-first
		rdata_q <= mem[word_addr];
	end

	assign rdata = rdata_q;
	assign ctrl.store_rdata = rdata_q;

endmodule

// File: source/qpi_cache_top.sv
`timescale 1ns/1ps

module qpi_cache_top (
	input  logic                                  clk,
	input  logic                                  rst,
	// Requester port
	input  logic [qpi_cache_pkg::ADDR_WIDTH-1:0]  addr,
	input  logic                                  ren,
	input  logic [3:0]                            wen,
	input  logic [31:0]                           wdata,
	output logic [31:0]                           rdata,
	output logic                                  ready,
	// Quad-SPI controller port
	output logic                                  qpi_do_read,
	output logic                                  qpi_do_write,
	input  logic                                  qpi_next_byte,
	output logic [qpi_cache_pkg::QADDR_WIDTH-1:0] qpi_addr,
	output logic [31:0]                           qpi_wdata,
	input  logic [31:0]                           qpi_rdata,
	input  logic                                  qpi_is_idle
);

	cache_ctrl_if ctrl ();

	// Tag and flag lookup
	cache_tag_lookup u_lookup (
		.clk  (clk),
		.rst  (rst),
		.addr (addr),
		.ren  (ren),
		.wen  (wen),
		.ctrl (ctrl.lookup)
	);

	// Writeback and refill sequencer
	cache_refill_seq u_seq (
		.clk           (clk),
		.rst           (rst),
		.addr          (addr),
		.ren           (ren),
		.wen           (wen),
		.ready         (ready),
		.qpi_do_read   (qpi_do_read),
		.qpi_do_write  (qpi_do_write),
		.qpi_next_byte (qpi_next_byte),
		.qpi_addr      (qpi_addr),
		.qpi_wdata     (qpi_wdata),
		.qpi_is_idle   (qpi_is_idle),
		.ctrl          (ctrl.refill)
	);

	// Line data and read path
	cache_data_store u_store (
		.clk       (clk),
		.addr      (addr),
		.wen       (wen),
		.wdata     (wdata),
		.qpi_rdata (qpi_rdata),
		.rdata     (rdata),
		.ctrl      (ctrl.store)
	);

endmodule

// File: verif/qpi_mem_model.sv
`timescale 1ns/1ps

module qpi_mem_model #(
	parameter int MAX_DELAY = 4
) (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  do_read,
	input  logic                                  do_write,
	input  logic [qpi_cache_pkg::QADDR_WIDTH-1:0] addr,
	input  logic [31:0]                           wdata,
	output logic                                  next_byte,
	output logic [31:0]                           rdata,
	output logic                                  is_idle
);
	import qpi_cache_pkg::*;

	localparam int WORDS = 1 << ADDR_WIDTH;

	logic [31:0]           mem [WORDS];
	logic [ADDR_WIDTH-1:0] word_addr;
	logic                  writing;

	// Known contents, each address bit appears twice in the word
	function automatic logic [31:0] fill_word(input logic [ADDR_WIDTH-1:0] a);
		return {4'ha, a, ~a, 4'h5};
	endfunction

	initial begin
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = fill_word(i[ADDR_WIDTH-1:0]);
		end
		next_byte = 1'b0;
		rdata = '0;
		is_idle = 1'b1;
		forever begin
			@(posedge clk);
			if (!rst && (do_read || do_write)) begin
				// Line base is only valid at the start of the transfer
				writing = do_write;
				word_addr = addr[QADDR_WIDTH-1:2];
				is_idle <= 1'b0;
				for (int w = 0; w < LINE_WORDS; w++) begin
					// Serial shifting takes a variable number of cycles per word
					repeat ($urandom_range(MAX_DELAY, 1)) @(posedge clk);
					next_byte <= 1'b1;
					if (!writing) begin
						rdata <= mem[word_addr];
					end
					@(posedge clk);
					// Write word is taken on the strobe edge
					if (writing) begin
						mem[word_addr] = wdata;
					end
					next_byte <= 1'b0;
					word_addr = word_addr + 1'b1;
				end
				// Chip select recovery time
				repeat (2) @(posedge clk);
				is_idle <= 1'b1;
			end
		end
	end

endmodule

// File: verif/tb_qpi_cache.sv
`timescale 1ns/1ps

module tb_qpi_cache;
	import qpi_cache_pkg::*;

	localparam int unsigned SEED = 32'hbb11d9ed;
	localparam int TIMEOUT = 2000;
	localparam int HIT_LATENCY = 2;
	localparam int MODEL_MAX_DELAY = 4;

	logic                   clk;
	logic                   rst;
	logic [ADDR_WIDTH-1:0]  addr;
	logic                   ren;
	logic [3:0]             wen;
	logic [31:0]            wdata;
	logic [31:0]            rdata;
	logic                   ready;
	logic                   qpi_do_read;
	logic                   qpi_do_write;
	logic                   qpi_next_byte;
	logic [QADDR_WIDTH-1:0] qpi_addr;
	logic [31:0]            qpi_wdata;
	logic [31:0]            qpi_rdata;
	logic                   qpi_is_idle;

	// Expected memory contents as seen by the requester
	logic [31:0] ref_mem [1 << ADDR_WIDTH];
	int          errors;
	int          last_latency;
	// Controller transfers in the order they started
	bit          xfer_write [$];
	int          xfer_addr [$];
	logic        xfer_active;

	qpi_cache_top UUT (.*);

	qpi_mem_model #(.MAX_DELAY(MODEL_MAX_DELAY)) u_mem (
		.clk       (clk),
		.rst       (rst),
		.do_read   (qpi_do_read),
		.do_write  (qpi_do_write),
		.addr      (qpi_addr),
		.wdata     (qpi_wdata),
		.next_byte (qpi_next_byte),
		.rdata     (qpi_rdata),
		.is_idle   (qpi_is_idle)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Log each rising do_read or do_write with its byte address
	always @(posedge clk) begin
		xfer_active <= qpi_do_read || qpi_do_write;
		if ((qpi_do_read || qpi_do_write) && !xfer_active) begin
			xfer_write.push_back(qpi_do_write);
			xfer_addr.push_back(int'(qpi_addr));
		end
	end

	function automatic logic [31:0] initial_word(input logic [ADDR_WIDTH-1:0] a);
		return {4'ha, a, ~a, 4'h5};
	endfunction

	function automatic logic [ADDR_WIDTH-1:0] word_at(input int tag, input int set, input int off);
		return ADDR_WIDTH'((tag * SETS + set) * LINE_WORDS + off);
	endfunction

	task automatic end_run();
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	endtask

	// One request held until ready
	// A zero wen makes it a read
	task automatic access(input logic [ADDR_WIDTH-1:0] a, input logic [3:0] be,
		input logic [31:0] d, output logic [31:0] q);
		int cycles;
		addr = a;
		ren = (be == 4'b0000);
		wen = be;
		wdata = d;
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
		end while (!ready && cycles < TIMEOUT);
		assert (ready) else begin
			$display("Timed out after %0d cycles waiting for ready at address %h", cycles, a);
			errors++;
		end
		last_latency = cycles;
		q = rdata;
		ren = 1'b0;
		wen = 4'b0000;
		// Idle gap before the next request
		@(posedge clk);
		#1;
	endtask

	task automatic read_word(input logic [ADDR_WIDTH-1:0] a, input string what);
		logic [31:0] q;
		access(a, 4'b0000, 32'h0, q);
		assert (q === ref_mem[a]) else begin
			$display("[FAIL] %0t %s at %h: got %h, expected %h", $time, what, a, q, ref_mem[a]);
			errors++;
		end
	endtask

	task automatic write_word(input logic [ADDR_WIDTH-1:0] a, input logic [3:0] be,
		input logic [31:0] d);
		logic [31:0] q;
		access(a, be, d, q);
		// Only enabled bytes change
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				ref_mem[a][8*b +: 8] = d[8*b +: 8];
			end
		end
	endtask

	task automatic clear_log();
		xfer_write.delete();
		xfer_addr.delete();
	endtask

	task automatic expect_transfers(input int count, input string what);
		assert (xfer_addr.size() == count) else begin
			$display("[FAIL] %0t %s: %0d transfers, expected %0d", $time, what,
				xfer_addr.size(), count);
			errors++;
		end
	endtask

	// Transfer kind and line base byte address of a logged transfer
	task automatic compare_transfer(input int idx, input bit is_write,
		input logic [ADDR_WIDTH-1:0] a);
		int base;
		base = (int'(a) / LINE_WORDS) * LINE_WORDS * 4;
		if (idx < xfer_addr.size()) begin
			assert (xfer_write[idx] == is_write && xfer_addr[idx] == base) else begin
				$display("[FAIL] %0t transfer %0d: write=%0b at %h, expected write=%0b at %h",
					$time, idx, xfer_write[idx], xfer_addr[idx], is_write, base);
				errors++;
			end
		end
	endtask

	task automatic verify_latency(input string what);
		assert (last_latency == HIT_LATENCY) else begin
			$display("[FAIL] %0t %s: ready after %0d cycles, expected %0d", $time, what,
				last_latency, HIT_LATENCY);
			errors++;
		end
	endtask

	task automatic cold_read_miss();
		clear_log();
		read_word(word_at(4, 1, 1), "read miss");
		expect_transfers(1, "read miss");
		compare_transfer(0, 1'b0, word_at(4, 1, 1));
	endtask

	task automatic line_rereads();
		clear_log();
		for (int off = 0; off < LINE_WORDS; off++) begin
			read_word(word_at(4, 1, off), "read hit");
			verify_latency("read hit");
		end
		expect_transfers(0, "read hit");
	endtask

	task automatic byte_enable_merge();
		write_word(word_at(4, 1, 2), 4'b0101, 32'hdeadbeef);
		read_word(word_at(4, 1, 2), "byte write 0101");
		write_word(word_at(4, 1, 2), 4'b1000, 32'h12345678);
		read_word(word_at(4, 1, 2), "byte write 1000");
		write_word(word_at(4, 1, 3), 4'b0110, 32'hcafef00d);
		read_word(word_at(4, 1, 3), "byte write 0110");
	endtask

	// Two dirty lines in set 2 and a third tag that evicts the older one
	task automatic dirty_eviction();
		write_word(word_at(1, 2, 0), 4'b1111, 32'h0badcafe);
		write_word(word_at(2, 2, 1), 4'b0011, 32'h5555aaaa);
		clear_log();
		read_word(word_at(3, 2, 3), "third tag");
		expect_transfers(2, "dirty eviction");
		compare_transfer(0, 1'b1, word_at(1, 2, 0));
		compare_transfer(1, 1'b0, word_at(3, 2, 3));
		read_word(word_at(1, 2, 0), "evicted word");
	endtask

	task automatic lru_replacement();
		read_word(word_at(10, 5, 0), "tag A");
		read_word(word_at(11, 5, 1), "tag B");
		read_word(word_at(10, 5, 0), "tag A again");
		clear_log();
		read_word(word_at(12, 5, 2), "tag C");
		expect_transfers(1, "tag C");
		compare_transfer(0, 1'b0, word_at(12, 5, 2));
		// A must still be resident
		clear_log();
		read_word(word_at(10, 5, 0), "tag A after C");
		verify_latency("tag A after C");
		expect_transfers(0, "tag A after C");
		read_word(word_at(11, 5, 1), "tag B refetch");
		expect_transfers(1, "tag B refetch");
	endtask

	// Four tags share every set in this window
	task automatic random_traffic();
		logic [ADDR_WIDTH-1:0] a;
		for (int n = 0; n < 300; n++) begin
			a = ADDR_WIDTH'(12'h300 + $urandom_range(255, 0));
			if ($urandom_range(1, 0) == 1) begin
				write_word(a, 4'($urandom_range(15, 1)), $urandom);
			end else begin
				read_word(a, "random read");
			end
		end
	endtask

	initial begin
		void'($urandom(SEED));
		errors = 0;
		rst = 1'b1;
		addr = '0;
		ren = 1'b0;
		wen = 4'b0000;
		wdata = '0;
		for (int i = 0; i < (1 << ADDR_WIDTH); i++) begin
			ref_mem[i] = initial_word(i[ADDR_WIDTH-1:0]);
		end
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		cold_read_miss();
		line_rereads();
		byte_enable_merge();
		dirty_eviction();
		lru_replacement();
		random_traffic();
		end_run();
	end

endmodule

// File: filelist.f
source/qpi_cache_pkg.sv
source/cache_ctrl_if.sv
source/cache_tag_lookup.sv
source/cache_refill_seq.sv
source/cache_data_store.sv
source/qpi_cache_top.sv
verif/qpi_mem_model.sv
verif/tb_qpi_cache.sv

// File: Bender.yml
package:
  name: qpi_cache

sources:
  - files:
      - source/qpi_cache_pkg.sv
      - source/cache_ctrl_if.sv
      - source/cache_tag_lookup.sv
      - source/cache_refill_seq.sv
      - source/cache_data_store.sv
      - source/qpi_cache_top.sv
  - target: simulation
    files:
      - verif/qpi_mem_model.sv
      - verif/tb_qpi_cache.sv
